// ==== include/int_config.svh ====
// VECTOR_W must be wide enough to number all IRQ_LINES and ENTRY_STEPS may not exceed four
`ifndef INT_CONFIG_SVH
`define INT_CONFIG_SVH

//////////////////////////////
// Interrupt controller
//////////////////////////////

// Number of level request inputs
`define IRQ_LINES 8

// Bits needed to number one request line
`define VECTOR_W 3

//////////////////////////////
// Microcode sequencer
//////////////////////////////

// Width of the microcode action field
`define ACTION_W 4

// Width of the instruction opcode
`define OPCODE_W 4

// Cycles spent in the interrupt entry sequence
`define ENTRY_STEPS 2

`endif

// ==== verilog/ucode_pkg.sv ====
// Action encodings follow the microcode ROM and only the low three bits decode when bit 3 is clear
`include "int_config.svh"

package ucode_pkg;

   //////////////////////////////
   // Action field
   //////////////////////////////

   // Microcode action field, top bit set means no decode
   typedef logic [`ACTION_W-1:0] action_t;

   // Idle value with the decode disabled
   localparam action_t ACT_NONE = action_t'(8);
   // Set the interrupt flag
   localparam action_t ACT_STI = action_t'(3);
   // Clear the interrupt flag
   localparam action_t ACT_CLI = action_t'(4);
   // Index strobe to the control board
   localparam action_t ACT_IDX = action_t'(5);

   //////////////////////////////
   // Instruction format
   //////////////////////////////

   // Upper two bits pick the first-step action
   // Lower two bits hold the step count minus one
   typedef logic [`OPCODE_W-1:0] opcode_t;

   // Step counter, enough for four steps
   typedef logic [1:0] step_t;

   // Sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_EXEC,
      SEQ_ENTRY
   } seq_state_t;

endpackage

// ==== verilog/int_pkg.sv ====
// Request lines are numbered from zero and a lower number always has the higher priority
`include "int_config.svh"

package int_pkg;

   //////////////////////////////
   // Request side
   //////////////////////////////

   // One bit per request line
   // Shared by the request input, pending register and mask
   typedef logic [`IRQ_LINES-1:0] irq_vec_t;

   //////////////////////////////
   // Service side
   //////////////////////////////

   // Number of the line being serviced
   typedef logic [`VECTOR_W-1:0] vector_t;

endpackage

// ==== verilog/irq_controller.sv ====
// Requests are edge latched on clk4 so a level held high is taken once and a line must drop to retrigger
`timescale 1ns/1ns
`include "int_config.svh"

module irq_controller (
   input  logic              clk4,
   input  logic              rst_n,
   input  int_pkg::irq_vec_t irq_req,
   input  logic              mask_we,
   input  int_pkg::irq_vec_t mask_data,
   input  logic              irq_ack,
   output logic              irq,
   output int_pkg::vector_t  ack_vector
);

   import int_pkg::*;

   // Request sample from the previous edge
   irq_vec_t req_prev;
   // Rising edges seen this cycle
   irq_vec_t req_rise;
   // Latched requests waiting for service
   irq_vec_t pending;
   // One bit enables a line
   irq_vec_t mask;
   // Lines that are pending and enabled
   irq_vec_t active;
   // One-hot copy of the selected line
   irq_vec_t sel_hot;

   //////////////////////////////
   // Edge detect and pending
   //////////////////////////////

   assign req_rise = irq_req & ~req_prev;

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         req_prev <= '0;
         pending  <= '0;
      end else begin
         req_prev <= irq_req;
         // A fresh edge on the acked line keeps it pending
         if (irq_ack)
            pending <= (pending & ~sel_hot) | req_rise;
         else
            pending <= pending | req_rise;
      end
   end

   //////////////////////////////
   // Mask register
   //////////////////////////////

   // All lines enabled out of reset
   always_ff @(posedge clk4) begin
      if (!rst_n)
         mask <= '1;
      else if (mask_we)
         mask <= mask_data;
   end

   //////////////////////////////
   // Fixed priority select
   //////////////////////////////

   assign active = pending & mask;
   assign irq    = |active;

   // Scan from the top so the lowest active line is left in place
   always_comb begin
      ack_vector = '0;
      sel_hot    = '0;
      for (int i = `IRQ_LINES - 1; i >= 0; i--) begin
         if (active[i]) begin
            ack_vector = vector_t'(i);
            sel_hot    = irq_vec_t'(1) << i;
         end
      end
   end

endmodule

// ==== verilog/int_fsm.sv ====
// A request reaches irqs only at an instruction end at least two cycles after it is synchronized with FI set
`timescale 1ns/1ns

module int_fsm (
   input  logic               clk4,
   input  logic               rst_n,
   input  ucode_pkg::action_t action,
   input  logic               ibus15,
   input  logic               flag_we,
   input  logic               end_instr,
   input  logic               irq,
   output logic               fi,
   output logic               irqs,
   output logic               action_idx
);

   import ucode_pkg::*;

   // Decoded action strobes
   logic action_sti;
   logic action_cli;
   // Synchronizer stages
   logic irq_s1;
   logic irq_s2;

   //////////////////////////////
   // Action decode
   //////////////////////////////

   // Top bit set disables the decode so the full compare covers it
   assign action_sti = (action == ACT_STI);
   assign action_cli = (action == ACT_CLI);
   assign action_idx = (action == ACT_IDX);

   //////////////////////////////
   // Interrupt flag
   //////////////////////////////

   // CLI beats STI and STI beats a bus load
   always_ff @(posedge clk4) begin
      if (!rst_n || action_cli)
         fi <= 1'b0;
      else if (action_sti)
         fi <= 1'b1;
      else if (flag_we)
         fi <= ibus15;
   end

   //////////////////////////////
   // Request synchronizer
   //////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         irq_s1 <= 1'b0;
         irq_s2 <= 1'b0;
      end else begin
         irq_s1 <= irq;
         // Second stage held off while interrupts are disabled
         if (!fi || action_cli)
            irq_s2 <= 1'b0;
         else
            irq_s2 <= irq_s1;
      end
   end

   // Signal the sequencer only between instructions
   always_ff @(posedge clk4) begin
      if (!rst_n)
         irqs <= 1'b0;
      else if (end_instr)
         irqs <= irq_s2;
   end

endmodule

// ==== verilog/ucode_sequencer.sv ====
// instr_valid is dropped while busy or when an interrupt is taken and the source must wait for busy low
`timescale 1ns/1ns
`include "int_config.svh"

module ucode_sequencer (
   input  logic               clk4,
   input  logic               rst_n,
   input  logic               instr_valid,
   input  ucode_pkg::opcode_t opcode,
   input  logic               irqs,
   input  int_pkg::vector_t   ack_vector,
   output ucode_pkg::action_t action,
   output logic               end_instr,
   output logic               busy,
   output logic               irq_ack,
   output logic               int_taken,
   output int_pkg::vector_t   int_vector
);

   import ucode_pkg::*;

   seq_state_t state;
   // Counts up from zero within an instruction or entry
   step_t      step;
   // Opcode held for the length of the instruction
   opcode_t    op_q;
   // Index of the final step in the current sequence
   step_t      step_last;
   // Action of the first execute step
   action_t    first_act;
   logic       first_step;

   //////////////////////////////
   // Opcode decode
   //////////////////////////////

   always_comb begin
      case (op_q[`OPCODE_W-1 -: 2])
         2'd1:    first_act = ACT_STI;
         2'd2:    first_act = ACT_CLI;
         2'd3:    first_act = ACT_IDX;
         default: first_act = ACT_NONE;
      endcase
   end

   // Entry length is fixed and an instruction takes its count from the opcode
   assign step_last = (state == SEQ_EXEC) ? op_q[1:0] : step_t'(`ENTRY_STEPS - 1);

   //////////////////////////////
   // State machine
   //////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         state <= SEQ_IDLE;
         step  <= '0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               step <= '0;
               // Pending interrupt wins over a new instruction
               if (irqs)
                  state <= SEQ_ENTRY;
               else if (instr_valid)
                  state <= SEQ_EXEC;
            end
            SEQ_EXEC, SEQ_ENTRY: begin
               if (step == step_last) begin
                  state <= SEQ_IDLE;
                  step  <= '0;
               end else begin
                  step <= step + 2'd1;
               end
            end
            default: begin
               state <= SEQ_IDLE;
               step  <= '0;
            end
         endcase
      end
   end

   // Capture the opcode as the instruction is accepted
   always_ff @(posedge clk4) begin
      if (state == SEQ_IDLE && !irqs && instr_valid)
         op_q <= opcode;
   end

   // Hold the acked line number for the int_taken cycle
   always_ff @(posedge clk4) begin
      if (irq_ack)
         int_vector <= ack_vector;
   end

   //////////////////////////////
   // Outputs
   //////////////////////////////

   assign busy       = (state != SEQ_IDLE);
   assign first_step = busy && (step == '0);
   assign end_instr  = busy && (step == step_last);

   // Entry opens with CLI so FI is down before the handler runs
   always_comb begin
      if (state == SEQ_EXEC && first_step)
         action = first_act;
      else if (state == SEQ_ENTRY && first_step)
         action = ACT_CLI;
      else
         action = ACT_NONE;
   end

   assign irq_ack   = (state == SEQ_ENTRY) && first_step;
   assign int_taken = (state == SEQ_ENTRY) && end_instr;

endmodule

// ==== verilog/int_unit.sv ====
// Requests are active high levels on one internal line and the bus sees a single irqs output
`timescale 1ns/1ns

module int_unit (
   input  logic               clk4,
   input  logic               rst_n,
   input  logic               instr_valid,
   input  ucode_pkg::opcode_t opcode,
   input  logic               flag_we,
   input  logic               ibus15,
   input  logic               mask_we,
   input  int_pkg::irq_vec_t  mask_data,
   input  int_pkg::irq_vec_t  irq_req,
   output logic               busy,
   output logic               fi,
   output logic               irqs,
   output logic               action_idx,
   output logic               int_taken,
   output int_pkg::vector_t   int_vector
);

   import ucode_pkg::*;
   import int_pkg::*;

   // Sequencer to flag logic
   action_t action;
   logic    end_instr;
   // Controller and sequencer handshake lines
   logic    irq;
   logic    irq_ack;
   vector_t ack_vector;

   //////////////////////////////
   // Request side
   //////////////////////////////

   irq_controller u_irq_controller (
      .clk4       (clk4),
      .rst_n      (rst_n),
      .irq_req    (irq_req),
      .mask_we    (mask_we),
      .mask_data  (mask_data),
      .irq_ack    (irq_ack),
      .irq        (irq),
      .ack_vector (ack_vector)
   );

   // Flag, synchronizer and end of instruction register
   int_fsm u_int_fsm (
      .clk4       (clk4),
      .rst_n      (rst_n),
      .action     (action),
      .ibus15     (ibus15),
      .flag_we    (flag_we),
      .end_instr  (end_instr),
      .irq        (irq),
      .fi         (fi),
      .irqs       (irqs),
      .action_idx (action_idx)
   );

   //////////////////////////////
   // Control side
   //////////////////////////////

   ucode_sequencer u_ucode_sequencer (
      .clk4        (clk4),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .opcode      (opcode),
      .irqs        (irqs),
      .ack_vector  (ack_vector),
      .action      (action),
      .end_instr   (end_instr),
      .busy        (busy),
      .irq_ack     (irq_ack),
      .int_taken   (int_taken),
      .int_vector  (int_vector)
   );

endmodule

// ==== verif/int_unit_tb.sv ====
// Run from the project root so verif/int_unit_testdata.txt resolves and each line holds four fields
`timescale 1ns/1ns

module int_unit_tb;

   import ucode_pkg::*;
   import int_pkg::*;

   // DUT inputs start in their reset values
   logic        clk4 = 1'b0;
   logic        rst_n = 1'b0;
   logic        instr_valid = 1'b0;
   opcode_t     opcode = '0;
   logic        flag_we = 1'b0;
   logic        ibus15 = 1'b0;
   logic        mask_we = 1'b0;
   irq_vec_t    mask_data = '1;
   irq_vec_t    irq_req = '0;
   logic        busy, fi, irqs, action_idx, int_taken;
   vector_t     int_vector;
   // Each entry packs command letter and three hex arguments
   logic [31:0] cmd_q[$];
   logic [7:0]  c, a, b, d;
   logic [31:0] lfsr = 32'd71942;
   logic        loaded = 1'b0;
   int          fd;
   int          errors = 0;
   int          start_err = 0;
   int          n_pass = 0;

   int_unit dut_i (.*);

   // 40 ns period
   always #20 clk4 = ~clk4;

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Galois LFSR, maximal 32 bit polynomial
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
   endfunction

   task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
   endtask

   // Zero to three idle cycles, one LFSR step per bit
   task automatic idle_gap();
      int gap;
      gap = 0;
      repeat (2) begin
         lfsr = lfsr_step(lfsr);
         gap  = (gap << 1) | lfsr[0];
      end
      repeat (gap) @(posedge clk4);
   endtask

   // One cycle strobe on the flag write, mask write or request lines
   task automatic strobe_input(logic [7:0] cmd, logic [7:0] val);
      @(posedge clk4);
      #2;
      flag_we   = (cmd == "W");
      ibus15    = val[0];
      mask_we   = (cmd == "M");
      mask_data = val;
      irq_req   = (cmd == "P") ? val : '0;
      @(posedge clk4);
      #2;
      flag_we = 1'b0;
      mask_we = 1'b0;
      irq_req = '0;
   endtask

   // Issue one instruction and follow it until busy drops
   task automatic run_instr(logic [7:0] op, logic [7:0] req, logic [7:0] fw);
      int   n_busy;
      int   len;
      logic idx_exp;
      n_busy = 0;
      len    = op[1:0] + 1;
      @(posedge clk4);
      #2;
      instr_valid = 1'b1;
      opcode      = op[3:0];
      @(posedge clk4);
      #2;
      // Request pulse and bus write share the first busy cycle
      instr_valid = 1'b0;
      irq_req     = req;
      flag_we     = fw[1];
      ibus15      = fw[0];
      @(negedge clk4);
      while (busy && n_busy < 40) begin
         // end_instr marks the last step only
         if (dut_i.end_instr !== (n_busy == len - 1))
            report_mismatch("end_instr", n_busy == len - 1, dut_i.end_instr);
         // IDX only on the first step of an IDX opcode
         idx_exp = (n_busy == 0) && (op[3:2] == 2'd3);
         if (action_idx !== idx_exp)
            report_mismatch("action_idx", idx_exp, action_idx);
         n_busy++;
         @(posedge clk4);
         #2;
         irq_req = '0;
         flag_we = 1'b0;
         @(negedge clk4);
      end
      if (n_busy != len)
         report_mismatch("busy cycles", len, n_busy);
   endtask

   // Window long enough for one full entry sequence
   task automatic expect_entry(int exp_cnt, logic [7:0] exp_vec);
      int seen;
      seen = 0;
      repeat (10) begin
         @(negedge clk4);
         if (int_taken) begin
            seen++;
            if (int_vector !== vector_t'(exp_vec))
               report_mismatch("int_vector", exp_vec, int_vector);
            // Request that opened the entry holds until the entry ends
            if (irqs !== 1'b1)
               report_mismatch("irqs", 1, irqs);
         end
      end
      // Idle with no entry means no request, and an entry leaves FI clear
      if (irqs !== 1'b0)
         report_mismatch("irqs", 0, irqs);
      if (exp_cnt != 0 && seen == 0) begin
         $display("%0t interrupt entry was expected but int_taken never pulsed", $time);
         errors++;
      end else if (seen != exp_cnt) begin
         report_mismatch("int_taken pulses", exp_cnt, seen);
      end
   endtask

   //////////////////////////////
   // Command loop
   //////////////////////////////

   initial begin
      fd = $fopen("verif/int_unit_testdata.txt", "r");
      if (fd == 0) begin
         $display("test data file could not be opened");
         errors++;
      end
      while (fd != 0 && $fscanf(fd, " %c %h %h %h", c, a, b, d) == 4)
         cmd_q.push_back({c, a, b, d});
      loaded = 1'b1;
      repeat (5) @(posedge clk4);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < cmd_q.size(); i++) begin
         {c, a, b, d} = cmd_q[i];
         // Random spacing only ahead of driven commands
         if (c == "I" || c == "W" || c == "M" || c == "P")
            idle_gap();
         case (c)
            "I": run_instr(a, b, d);
            "W", "M", "P": strobe_input(c, a);
            "K": begin
               @(negedge clk4);
               if (fi !== a[0])
                  report_mismatch("fi", a[0], fi);
            end
            "V": expect_entry(a, b);
            "E": begin
               if (errors == start_err)
                  n_pass++;
               $display("test %0d finished with %0d errors", a, errors - start_err);
               start_err = errors;
            end
            default: begin
               $display("unknown command %c in test data", c);
               errors++;
            end
         endcase
      end
      $display("tests passed %0d, errors %0d", n_pass, errors);
      if (errors == 0 && n_pass > 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // Budget of 40 cycles per command plus the reset cycles
   initial begin
      wait (loaded);
      #((cmd_q.size() * 40 + 5) * 40);
      $display("timeout, the command list did not complete in time");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
verilog/ucode_pkg.sv
verilog/int_pkg.sv
verilog/irq_controller.sv
verilog/int_fsm.sv
verilog/ucode_sequencer.sv
verilog/int_unit.sv
verif/int_unit_tb.sv

// ==== Bender.yml ====
package:
  name: int_unit
export_include_dirs:
  - include
sources:
  - verilog/ucode_pkg.sv
  - verilog/int_pkg.sv
  - verilog/irq_controller.sv
  - verilog/int_fsm.sv
  - verilog/ucode_sequencer.sv
  - verilog/int_unit.sv
  - target: test
    files:
      - verif/int_unit_tb.sv

// ==== verif/int_unit_testdata.txt ====
W 1 0 0
K 1 0 0
I 8 0 3
K 0 0 0
I 4 0 2
K 1 0 0
W 0 0 0
K 0 0 0
I 4 0 0
K 1 0 0
E 1 0 0
I c 0 0
I d 0 0
E 2 0 0
I 0 0 0
I 2 0 0
I 3 0 0
E 3 0 0
I 3 1 0
V 1 0 0
K 0 0 0
E 4 0 0
W 1 0 0
M fe 0 0
P 1 0 0
I 3 0 0
V 0 0 0
W 0 0 0
P 2 0 0
I 3 0 0
V 0 0 0
I 7 0 0
V 1 1 0
E 5 0 0
P 68 0 0
I 7 0 0
V 1 3 0
I 7 0 0
V 1 5 0
I 7 0 0
V 1 6 0
I 7 0 0
V 0 0 0
E 6 0 0
